/* design/fetch_pkg.sv */
package fetch_pkg;

    // fetch start address after reset
    localparam logic [31:0] pc_reset = 32'h1c00_0000;

    // andi r0, r0, 0
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // fetch queue between the stage register and decode
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;

endpackage

/* design/serial_pkg.sv */
package serial_pkg;

    // ibar hint matched on register view bits 31..15
    localparam logic [16:0] ibar_op = 17'h070e5;
    // csrrd, csrwr and csrxchg matched on csr view bits 31..24
    localparam logic [7:0]  csr_op  = 8'h04;
    // tlbsrch, tlbrd, tlbwr and tlbfill share this prefix
    localparam logic [16:0] tlb_op  = 17'h00c90;

    // kind of serializing instruction
    localparam logic [1:0] ser_none = 2'd0;
    localparam logic [1:0] ser_ibar = 2'd1;
    localparam logic [1:0] ser_csr  = 2'd2;
    localparam logic [1:0] ser_tlb  = 2'd3;

    // serializing fsm states
    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_wait_ex   = 2'd1;
    localparam logic [1:0] st_wait_done = 2'd2;

    // one instruction word seen as csr access or as three-register format
    typedef union packed {
        struct packed {
            logic [7:0]  opcode;
            logic [13:0] csr_num;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } csr;
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } rv;
    } inst_word_u;

endpackage

/* design/if_predecode.sv */
`timescale 1ns/100ps

module if_predecode (
    input  logic [31:0]            in_pc,
    input  serial_pkg::inst_word_u in_inst0,
    input  serial_pkg::inst_word_u in_inst1,
    output logic [1:0]             ser_kind,
    output logic                   ser_slot1
);
    import serial_pkg::*;

    logic [1:0] kind0;
    logic [1:0] kind1;

    // ibar wins over csr, csr over tlb
    function automatic logic [1:0] classify(input inst_word_u w);
        if (w.rv.opcode == ibar_op) begin
            return ser_ibar;
        end else if (w.csr.opcode == csr_op) begin
            return ser_csr;
        end else if (w.rv.opcode == tlb_op) begin
            return ser_tlb;
        end
        return ser_none;
    endfunction

    always_comb begin
        // packet starting at the upper word has no valid slot 0
        if (in_pc[2]) begin
            kind0 = ser_none;
        end else begin
            kind0 = classify(in_inst0);
        end
        kind1 = classify(in_inst1);
    end

    // first serializing slot in program order
    always_comb begin
        if (kind0 != ser_none) begin
            ser_kind  = kind0;
            ser_slot1 = 1'b0;
        end else begin
            ser_kind  = kind1;
            ser_slot1 = (kind1 != ser_none);
        end
    end

endmodule

/* design/if1_stage_reg.sv */
`timescale 1ns/100ps

module if1_stage_reg (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        in_valid,
    output logic        in_allowin,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_pc_next,
    input  logic [31:0] in_inst0,
    input  logic [31:0] in_inst1,
    input  logic [1:0]  ser_kind,
    input  logic        ser_slot1,
    output logic        stg_valid,
    input  logic        stg_allowin,
    output logic [31:0] stg_pc,
    output logic [31:0] stg_pc_next,
    output logic [31:0] stg_inst0,
    output logic [31:0] stg_inst1,
    input  logic        ex_commit,
    input  logic        icache_idle,
    input  logic        dcache_idle,
    input  logic        csr_done,
    input  logic        tlb_done,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);
    import fetch_pkg::*;
    import serial_pkg::*;

    logic [1:0]  state;
    logic [1:0]  state_nxt;
    logic [1:0]  wait_kind;
    logic        done_event;
    logic        in_fire;
    logic        is_serial;
    logic        stg_load;
    logic        hold_wr;
    logic        hold_valid;
    logic [31:0] hold_pc;
    logic [31:0] hold_pc_next;
    logic [31:0] hold_inst0;
    logic [31:0] hold_inst1;
    logic [31:0] cap_inst0;
    logic [31:0] cap_inst1;

    assign is_serial  = (ser_kind != ser_none);
    assign in_allowin = !flush && !hold_valid && (state == st_idle);
    assign in_fire    = in_valid && in_allowin;

    // a stalled stage register pushes the new packet into the hold buffer
    assign stg_load = in_fire && (!stg_valid || stg_allowin);
    assign hold_wr  = in_fire && stg_valid && !stg_allowin;

    // slot masking applied once at capture
    assign cap_inst0 = in_pc[2] ? inst_nop : in_inst0;
    assign cap_inst1 = (is_serial && !ser_slot1) ? inst_nop : in_inst1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stg_valid  <= 1'b0;
            hold_valid <= 1'b0;
        end else if (flush) begin
            stg_valid  <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            stg_valid  <= stg_load || hold_valid || (stg_valid && !stg_allowin);
            hold_valid <= hold_wr || (hold_valid && !stg_allowin);
        end
    end

    always_ff @(posedge clk) begin
        if (hold_valid && stg_allowin) begin
            stg_pc      <= hold_pc;
            stg_pc_next <= hold_pc_next;
            stg_inst0   <= hold_inst0;
            stg_inst1   <= hold_inst1;
        end else if (stg_load) begin
            stg_pc      <= in_pc;
            stg_pc_next <= in_pc_next;
            stg_inst0   <= cap_inst0;
            stg_inst1   <= cap_inst1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_wr) begin
            hold_pc      <= in_pc;
            hold_pc_next <= in_pc_next;
            hold_inst0   <= cap_inst0;
            hold_inst1   <= cap_inst1;
        end
    end

    // completion event depends on what kind of instruction we wait for
    always_comb begin
        case (wait_kind)
            ser_ibar: done_event = icache_idle && dcache_idle;
            ser_csr:  done_event = csr_done;
            ser_tlb:  done_event = tlb_done;
            default:  done_event = 1'b1;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (in_fire && is_serial) begin
                    state_nxt = st_wait_ex;
                end
            end
            st_wait_ex: begin
                if (ex_commit) begin
                    state_nxt = st_wait_done;
                end
            end
            st_wait_done: begin
                if (done_event) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= st_idle;
            wait_kind   <= ser_none;
            redirect_pc <= pc_reset;
        end else if (flush) begin
            state     <= st_idle;
            wait_kind <= ser_none;
        end else begin
            state <= state_nxt;
            if (in_fire && is_serial) begin
                wait_kind   <= ser_kind;
                redirect_pc <= in_pc + (ser_slot1 ? 32'd8 : 32'd4);
            end
        end
    end

    assign redirect_valid = (state != st_idle);

    // input closes on the cycle right after a serializing packet
    a_no_accept_after_serial: assert property (@(posedge clk) disable iff (!rstn || flush)
        in_fire && is_serial |=> (state == st_wait_ex) && !in_fire);

    a_redirect_pc_stable: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid ##1 redirect_valid |-> $stable(redirect_pc));

    // held packet sits behind a valid stage register
    a_hold_not_full: assert property (@(posedge clk) disable iff (!rstn || flush)
        hold_wr |-> !hold_valid ##1 (hold_valid && stg_valid));

endmodule

/* design/inst_queue.sv */
`timescale 1ns/100ps

module inst_queue (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        stg_valid,
    output logic        stg_allowin,
    input  logic [31:0] stg_pc,
    input  logic [31:0] stg_pc_next,
    input  logic [31:0] stg_inst0,
    input  logic [31:0] stg_inst1,
    output logic        out_valid,
    input  logic        out_allowin,
    output logic [31:0] out_pc,
    output logic [31:0] out_pc_next,
    output logic [31:0] out_inst0,
    output logic [31:0] out_inst1
);
    import fetch_pkg::*;

    logic [31:0]            q_pc      [queue_depth];
    logic [31:0]            q_pc_next [queue_depth];
    logic [31:0]            q_inst0   [queue_depth];
    logic [31:0]            q_inst1   [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   count;
    logic                   wr_en;
    logic                   rd_en;

    // advance a pointer and wrap after the last entry
    function automatic logic [queue_ptr_w-1:0] ptr_inc(input logic [queue_ptr_w-1:0] p);
        if (p == queue_ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign stg_allowin = (count != (queue_ptr_w + 1)'(queue_depth));
    assign out_valid   = (count != '0);
    assign wr_en       = stg_valid && stg_allowin;
    assign rd_en       = out_valid && out_allowin;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop leaves count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            q_pc[wr_ptr]      <= stg_pc;
            q_pc_next[wr_ptr] <= stg_pc_next;
            q_inst0[wr_ptr]   <= stg_inst0;
            q_inst1[wr_ptr]   <= stg_inst1;
        end
    end

    // head entry straight from storage
    assign out_pc      = q_pc[rd_ptr];
    assign out_pc_next = q_pc_next[rd_ptr];
    assign out_inst0   = q_inst0[rd_ptr];
    assign out_inst1   = q_inst1[rd_ptr];

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= (queue_ptr_w + 1)'(queue_depth));

endmodule

/* design/fetch_frontend.sv */
`timescale 1ns/100ps

module fetch_frontend (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        in_valid,
    output logic        in_allowin,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_pc_next,
    input  logic [31:0] in_inst0,
    input  logic [31:0] in_inst1,
    output logic        out_valid,
    input  logic        out_allowin,
    output logic [31:0] out_pc,
    output logic [31:0] out_pc_next,
    output logic [31:0] out_inst0,
    output logic [31:0] out_inst1,
    input  logic        ex_commit,
    input  logic        icache_idle,
    input  logic        dcache_idle,
    input  logic        csr_done,
    input  logic        tlb_done,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic [1:0]  ser_kind;
    logic        ser_slot1;
    logic        stg_valid;
    logic        stg_allowin;
    logic [31:0] stg_pc;
    logic [31:0] stg_pc_next;
    logic [31:0] stg_inst0;
    logic [31:0] stg_inst1;

    if_predecode i_if_predecode (
        .in_pc     (in_pc),
        .in_inst0  (in_inst0),
        .in_inst1  (in_inst1),
        .ser_kind  (ser_kind),
        .ser_slot1 (ser_slot1)
    );

    if1_stage_reg i_if1_stage_reg (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .in_pc          (in_pc),
        .in_pc_next     (in_pc_next),
        .in_inst0       (in_inst0),
        .in_inst1       (in_inst1),
        .ser_kind       (ser_kind),
        .ser_slot1      (ser_slot1),
        .stg_valid      (stg_valid),
        .stg_allowin    (stg_allowin),
        .stg_pc         (stg_pc),
        .stg_pc_next    (stg_pc_next),
        .stg_inst0      (stg_inst0),
        .stg_inst1      (stg_inst1),
        .ex_commit      (ex_commit),
        .icache_idle    (icache_idle),
        .dcache_idle    (dcache_idle),
        .csr_done       (csr_done),
        .tlb_done       (tlb_done),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    inst_queue i_inst_queue (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .stg_valid   (stg_valid),
        .stg_allowin (stg_allowin),
        .stg_pc      (stg_pc),
        .stg_pc_next (stg_pc_next),
        .stg_inst0   (stg_inst0),
        .stg_inst1   (stg_inst1),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_pc      (out_pc),
        .out_pc_next (out_pc_next),
        .out_inst0   (out_inst0),
        .out_inst1   (out_inst1)
    );

endmodule

/* test/tb_fetch_frontend.sv */
`timescale 1ns/100ps

module tb_fetch_frontend;
    import fetch_pkg::*;
    import serial_pkg::*;

    localparam int num_pkts    = 64;
    localparam int cycle_limit = 40 * num_pkts;

    typedef struct packed {
        logic        ser0;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
    } pkt_t;

    logic        clk;
    logic        rstn = 1'b0;
    logic        flush = 1'b0;
    logic        in_valid = 1'b0;
    logic        in_allowin;
    logic [31:0] in_pc = pc_reset;
    logic [31:0] in_pc_next = pc_reset;
    logic [31:0] in_inst0 = inst_nop;
    logic [31:0] in_inst1 = inst_nop;
    logic        out_valid;
    logic        out_allowin = 1'b0;
    logic [31:0] out_pc;
    logic [31:0] out_pc_next;
    logic [31:0] out_inst0;
    logic [31:0] out_inst1;
    logic        ex_commit = 1'b0;
    logic        icache_idle = 1'b1;
    logic        dcache_idle = 1'b1;
    logic        csr_done = 1'b0;
    logic        tlb_done = 1'b0;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // reference model
    pkt_t        model_q[$];
    pkt_t        head;
    logic        model_empty = 1'b1;
    logic [1:0]  phase = st_idle;
    logic [1:0]  exp_kind = ser_none;
    logic [31:0] exp_redirect = '0;

    // stimulus state
    logic [15:0] lfsr = 16'd24;
    logic [1:0]  cur_kind = ser_none;
    logic        cur_slot1 = 1'b0;
    logic        flushed = 1'b0;
    logic [31:0] pc_base = pc_reset;
    int          n_sent = 0;
    int          cycles = 0;

    wire in_fire  = in_valid && in_allowin;
    wire out_fire = out_valid && out_allowin && !flush;
    // completion event for the kind being waited on
    wire done_now = (exp_kind == ser_ibar) ? (icache_idle && dcache_idle) :
                    (exp_kind == ser_csr) ? csr_done : tlb_done;

    fetch_frontend i_fetch_frontend (.*);

    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
        return r;
    endfunction

    // pick 0, 1, 2 gives ibar, csr, tlb; anything else a plain add.w
    function automatic logic [31:0] build_inst(input logic [2:0] pick);
        inst_word_u w;
        w = 32'(rand_bits(15));
        case (pick)
            3'd0: w.rv.opcode = ibar_op;
            3'd1: w.csr.opcode = csr_op;
            3'd2: w.rv.opcode = tlb_op;
            default: w.rv.opcode = 17'h00020;
        endcase
        return w;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error in %s: expected %h, actual %h", test, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "check %s failed", test);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic next_packet();
        logic [31:0] pc;
        logic [2:0]  p0;
        logic [2:0]  p1;
        logic [1:0]  k0;
        logic [1:0]  k1;
        pc      = pc_base | ((rand_bits(1) != 0) ? 32'd4 : 32'd0);
        pc_base = pc_base + 32'd8;
        p0      = 3'(rand_bits(3));
        p1      = 3'(rand_bits(3));
        // slot 0 is outside the packet when pc bit 2 is set
        k0 = (pc[2] || p0 > 3'd2) ? ser_none : (p0 == 3'd0) ? ser_ibar :
             (p0 == 3'd1) ? ser_csr : ser_tlb;
        k1 = (p1 > 3'd2) ? ser_none : (p1 == 3'd0) ? ser_ibar :
             (p1 == 3'd1) ? ser_csr : ser_tlb;
        in_valid   <= 1'b1;
        in_pc      <= pc;
        in_pc_next <= pc + (pc[2] ? 32'd4 : 32'd8);
        in_inst0   <= build_inst(p0);
        in_inst1   <= build_inst(p1);
        cur_kind   <= (k0 != ser_none) ? k0 : k1;
        cur_slot1  <= (k0 == ser_none);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        wait (n_sent == num_pkts);
        @(negedge clk);
        while (!model_empty) begin
            @(negedge clk);
        end
        // a few more edges so the last checks get sampled
        repeat (2) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // source, decode sink and execute/cache responder
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            abort_run("timeout: the run hung before all packets drained");
        end else if (rstn) begin
            out_allowin <= (rand_bits(2) != 0);
            icache_idle <= (rand_bits(1) != 0);
            dcache_idle <= (rand_bits(1) != 0);
            csr_done    <= (rand_bits(2) == 0);
            tlb_done    <= (rand_bits(2) == 0);
            ex_commit   <= redirect_valid && (rand_bits(2) == 0);
            flush       <= 1'b0;
            if (n_sent == num_pkts / 2 && !flushed) begin
                flush   <= 1'b1;
                flushed = 1'b1;
            end
            if (in_fire) begin
                n_sent++;
            end
            if (in_fire || !in_valid) begin
                if (n_sent < num_pkts && rand_bits(2) != 0) begin
                    next_packet();
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        pkt_t p;
        if (flush) begin
            model_q.delete();
            phase = st_idle;
        end else if (rstn) begin
            if (out_fire && model_q.size() != 0) begin
                void'(model_q.pop_front());
            end
            if (in_fire) begin
                p.ser0    = (cur_kind != ser_none) && !cur_slot1;
                p.pc      = in_pc;
                p.pc_next = in_pc_next;
                p.inst0   = in_pc[2] ? inst_nop : in_inst0;
                p.inst1   = p.ser0 ? inst_nop : in_inst1;
                model_q.push_back(p);
            end
            // wait sequence expects commit first and the completion event after it
            if (in_fire && cur_kind != ser_none) begin
                phase        = st_wait_ex;
                exp_kind     = cur_kind;
                exp_redirect = in_pc + (cur_slot1 ? 32'd8 : 32'd4);
            end else if (phase == st_wait_ex && ex_commit) begin
                phase = st_wait_done;
            end else if (phase == st_wait_done && done_now) begin
                phase = st_idle;
            end
        end
        model_empty = (model_q.size() == 0);
        if (!model_empty) begin
            head = model_q[0];
        end
    end

    a_no_extra: assert property (@(posedge clk) disable iff (!rstn) out_valid |-> !model_empty)
        else abort_run("out_valid high with no packet expected");
    a_pc: assert property (@(posedge clk) disable iff (!rstn) out_fire |-> out_pc == head.pc)
        else report_mismatch("order_pc", $sampled(head.pc), $sampled(out_pc));
    a_pc_next: assert property (@(posedge clk) disable iff (!rstn)
        out_fire |-> out_pc_next == head.pc_next)
        else report_mismatch("order_pc_next", $sampled(head.pc_next), $sampled(out_pc_next));
    a_inst0: assert property (@(posedge clk) disable iff (!rstn)
        out_fire |-> out_inst0 == head.inst0)
        else report_mismatch("order_inst0", $sampled(head.inst0), $sampled(out_inst0));
    a_inst1: assert property (@(posedge clk) disable iff (!rstn)
        out_fire |-> out_inst1 == head.inst1)
        else report_mismatch("order_inst1", $sampled(head.inst1), $sampled(out_inst1));

    a_mask0: assert property (@(posedge clk) disable iff (!rstn)
        out_fire && out_pc[2] |-> out_inst0 == inst_nop)
        else report_mismatch("mask_slot0", inst_nop, $sampled(out_inst0));
    a_mask1: assert property (@(posedge clk) disable iff (!rstn)
        out_fire && head.ser0 |-> out_inst1 == inst_nop)
        else report_mismatch("mask_slot1", inst_nop, $sampled(out_inst1));

    a_redirect_rise: assert property (@(posedge clk) disable iff (!rstn)
        in_fire && cur_kind != ser_none |=> redirect_valid)
        else abort_run("redirect_valid did not rise after a serializing packet");
    a_redirect_pc: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid |-> redirect_pc == exp_redirect)
        else report_mismatch("redirect_pc", $sampled(exp_redirect), $sampled(redirect_pc));

    a_fetch_closed: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid |-> !in_allowin)
        else abort_run("in_allowin high while waiting on a serializing instruction");
    a_serial_wait: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid == (phase != st_idle))
        else report_mismatch("serial_wait", $sampled(phase != st_idle), $sampled(redirect_valid));

    a_flush: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !out_valid && !redirect_valid)
        else abort_run("queue or redirect still active after flush");
    a_reset: assert property (@(posedge clk)
        $rose(rstn) |-> !out_valid && !redirect_valid && in_allowin)
        else abort_run("wrong handshake state in the first cycle after reset");

endmodule

/* fetch_frontend.f */
design/fetch_pkg.sv
design/serial_pkg.sv
design/if_predecode.sv
design/if1_stage_reg.sv
design/inst_queue.sv
design/fetch_frontend.sv
test/tb_fetch_frontend.sv
